// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  # packages first, the RTL refers to them by scoped name
  - common/fetch_pkg.sv
  - common/icache_pkg.sv
  # design
  - logic/cf_arbiter.sv
  - fetch/fip_bank.sv
  - icache/icache_bank.sv
  - logic/fetch_unit.sv
  # testbench
  - target: test
    files:
      - verification/tb_fetch_unit.sv

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // address geometry
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 32;                   // byte address
    localparam int LINE_OFF_W = 4;                    // 16 byte lines
    localparam int FIP_W      = ADDR_W - LINE_OFF_W;  // line address

    // line address as a type, handy for casts
    typedef logic [FIP_W-1:0] fip_t;

    // each bank walks every other line
    localparam fip_t FIP_STEP = 2;

    ////////////////////////////////////////////////////////////
    // control-flow sources
    ////////////////////////////////////////////////////////////

    // highest value is highest priority
    typedef enum logic [1:0] {
        CF_NONE    = 2'd0,  // sequential fetch
        CF_BRANCH  = 2'd1,  // predicted taken branch
        CF_RESTEER = 2'd2,  // redirect from writeback
        CF_INIT    = 2'd3   // start of execution
    } cf_sel_e;

endpackage

// ==== common/icache_pkg.sv ====
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // line store geometry
    ////////////////////////////////////////////////////////////

    localparam int LINE_W = 128;  // one line of instruction bytes

    // index sits just above the bank parity bit
    localparam int INDEX_W = 3;
    localparam int LINES   = 2 ** INDEX_W;  // entries per bank

    // everything above the index is tag
    localparam int TAG_W = fetch_pkg::FIP_W - INDEX_W - 1;

    // bit positions inside a line address
    localparam int INDEX_LSB = 1;
    localparam int TAG_LSB   = INDEX_W + 1;

endpackage

// ==== fetch/fip_bank.sv ====
`timescale 1ns/1ns

module fip_bank #(
    parameter bit PARITY = 1'b0  // 0 for the even bank, 1 for the odd bank
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  fetch_pkg::cf_sel_e          cf_sel_i,
    input  logic [fetch_pkg::FIP_W-1:0] init_fip_i,
    input  logic [fetch_pkg::FIP_W-1:0] wb_fip_i,
    input  logic [fetch_pkg::FIP_W-1:0] bp_fip_i,
    input  logic                        latch_loaded_i,
    output logic [fetch_pkg::FIP_W-1:0] fip_o
);

    logic [fetch_pkg::FIP_W-1:0] fip_q;   // sequential line
    logic                        fip_ld;

    ////////////////////////////////////////////////////////////
    // line select
    ////////////////////////////////////////////////////////////

    // redirects bypass the register so the new line goes out this cycle
    always_comb begin
        case (cf_sel_i)
            fetch_pkg::CF_INIT:    fip_o = init_fip_i;
            fetch_pkg::CF_RESTEER: fip_o = wb_fip_i;
            fetch_pkg::CF_BRANCH:  fip_o = bp_fip_i;
            default:               fip_o = fip_q;
        endcase
    end

    // step on any redirect or when downstream took the line
    assign fip_ld = (cf_sel_i != fetch_pkg::CF_NONE) || latch_loaded_i;

    ////////////////////////////////////////////////////////////
    // sequential register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_q <= {{(fetch_pkg::FIP_W-1){1'b0}}, PARITY};  // line 0 or line 1
        end else if (fip_ld) begin
            fip_q <= fip_o + fetch_pkg::FIP_STEP;  // skip the other bank's line
        end
    end

    // redirect sources must deliver lines of this bank's parity
    a_fip_parity: assert property (
        @(posedge clk) disable iff (reset_i)
        fip_q[0] == PARITY
    ) else $error("fip_bank %0d: register left its parity, fip_q %0h", PARITY, fip_q);

endmodule

// ==== fetch_unit.f ====
common/fetch_pkg.sv
common/icache_pkg.sv
logic/cf_arbiter.sv
fetch/fip_bank.sv
icache/icache_bank.sv
logic/fetch_unit.sv
verification/tb_fetch_unit.sv

// ==== icache/icache_bank.sv ====
`timescale 1ns/1ns

module icache_bank (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic [fetch_pkg::FIP_W-1:0]   fip_i,
    input  logic                          fill_i,
    input  logic [fetch_pkg::FIP_W-1:0]   fill_fip_i,
    input  logic [icache_pkg::LINE_W-1:0] fill_line_i,
    output logic [icache_pkg::LINE_W-1:0] line_o,
    output logic                          miss_o
);

    // entry storage
    logic [icache_pkg::TAG_W-1:0]  tag_mem  [icache_pkg::LINES];
    logic [icache_pkg::LINE_W-1:0] data_mem [icache_pkg::LINES];
    logic [icache_pkg::LINES-1:0]  valid_q;

    // lookup side
    logic [icache_pkg::INDEX_W-1:0] rd_index;
    logic [icache_pkg::TAG_W-1:0]   rd_tag;
    logic                           rd_hit;

    // fill side
    logic [icache_pkg::INDEX_W-1:0] wr_index;
    logic [icache_pkg::TAG_W-1:0]   wr_tag;

    ////////////////////////////////////////////////////////////
    // address fields
    ////////////////////////////////////////////////////////////

    // bit 0 only picks the bank, so it is not part of index or tag
    assign rd_index = fip_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
    assign rd_tag   = fip_i[fetch_pkg::FIP_W-1:icache_pkg::TAG_LSB];

    assign wr_index = fill_fip_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
    assign wr_tag   = fill_fip_i[fetch_pkg::FIP_W-1:icache_pkg::TAG_LSB];

    assign rd_hit = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);

    ////////////////////////////////////////////////////////////
    // fill
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= fill_line_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;  // whole bank empty
        end else if (fill_i) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered lookup
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        line_o <= data_mem[rd_index];  // only meaningful with miss_o low
    end

    // a bank busy with a fill does not hand out lines
    always_ff @(posedge clk) begin
        if (reset_i) begin
            miss_o <= 1'b0;
        end else begin
            miss_o <= fill_i || !rd_hit;
        end
    end

    // no spurious miss right out of reset
    a_miss_after_reset: assert property (
        @(posedge clk) reset_i |=> !miss_o
    ) else $error("icache_bank: miss_o high in the cycle after reset");

endmodule

// ==== logic/cf_arbiter.sv ====
`timescale 1ns/1ns

module cf_arbiter (
    input  logic                         init_i,
    input  logic                         resteer_i,
    input  logic                         branch_i,
    input  logic [fetch_pkg::ADDR_W-1:0] init_addr_i,
    output fetch_pkg::cf_sel_e           cf_sel_o,
    output logic [fetch_pkg::FIP_W-1:0]  init_fip_even_o,
    output logic [fetch_pkg::FIP_W-1:0]  init_fip_odd_o
);

    logic [fetch_pkg::FIP_W-1:0] init_line;       // line holding init_addr_i
    logic [fetch_pkg::FIP_W-1:0] init_line_next;  // the line after it

    ////////////////////////////////////////////////////////////
    // source priority
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (init_i) begin
            cf_sel_o = fetch_pkg::CF_INIT;
        end else if (resteer_i) begin
            cf_sel_o = fetch_pkg::CF_RESTEER;  // writeback beats the predictor
        end else if (branch_i) begin
            cf_sel_o = fetch_pkg::CF_BRANCH;
        end else begin
            cf_sel_o = fetch_pkg::CF_NONE;
        end
    end

    ////////////////////////////////////////////////////////////
    // initial even/odd split
    ////////////////////////////////////////////////////////////

    assign init_line      = init_addr_i[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_OFF_W];
    assign init_line_next = init_line + fetch_pkg::fip_t'(1);

    // the bank matching the start line gets it, the other bank the next line
    always_comb begin
        if (init_line[0]) begin
            init_fip_odd_o  = init_line;
            init_fip_even_o = init_line_next;
        end else begin
            init_fip_even_o = init_line;
            init_fip_odd_o  = init_line_next;
        end
    end

    // no request must mean sequential fetch, and any request must redirect
    always_comb begin
        assert #0 ((cf_sel_o == fetch_pkg::CF_NONE) == !(init_i || resteer_i || branch_i))
            else $error("cf_arbiter: cf_sel_o %0h disagrees with requests", cf_sel_o);
    end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic                          clk,
    input  logic                          reset_i,
    // control flow
    input  logic                          init_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  init_addr_i,
    input  logic                          resteer_i,
    input  logic                          branch_i,
    input  logic [fetch_pkg::FIP_W-1:0]   wb_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]   wb_fip_odd_i,
    input  logic [fetch_pkg::FIP_W-1:0]   bp_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]   bp_fip_odd_i,
    // downstream latches
    input  logic                          latch_loaded_even_i,
    input  logic                          latch_loaded_odd_i,
    // line fill
    input  logic                          fill_even_i,
    input  logic                          fill_odd_i,
    input  logic [fetch_pkg::FIP_W-1:0]   fill_fip_i,
    input  logic [icache_pkg::LINE_W-1:0] fill_line_i,
    // fetch results
    output logic [fetch_pkg::FIP_W-1:0]   fip_even_o,
    output logic [fetch_pkg::FIP_W-1:0]   fip_odd_o,
    output logic [icache_pkg::LINE_W-1:0] line_even_o,
    output logic [icache_pkg::LINE_W-1:0] line_odd_o,
    output logic                          miss_even_o,
    output logic                          miss_odd_o
);

    fetch_pkg::cf_sel_e          cf_sel;
    logic [fetch_pkg::FIP_W-1:0] init_fip_even;
    logic [fetch_pkg::FIP_W-1:0] init_fip_odd;

    ////////////////////////////////////////////////////////////
    // control flow
    ////////////////////////////////////////////////////////////

    cf_arbiter i_cf_arbiter (
        .init_i          (init_i),
        .resteer_i       (resteer_i),
        .branch_i        (branch_i),
        .init_addr_i     (init_addr_i),
        .cf_sel_o        (cf_sel),
        .init_fip_even_o (init_fip_even),
        .init_fip_odd_o  (init_fip_odd)
    );

    ////////////////////////////////////////////////////////////
    // even bank
    ////////////////////////////////////////////////////////////

    fip_bank #(.PARITY(1'b0)) i_fip_bank_even (
        .clk            (clk),
        .reset_i        (reset_i),
        .cf_sel_i       (cf_sel),
        .init_fip_i     (init_fip_even),
        .wb_fip_i       (wb_fip_even_i),
        .bp_fip_i       (bp_fip_even_i),
        .latch_loaded_i (latch_loaded_even_i),
        .fip_o          (fip_even_o)
    );

    icache_bank i_icache_bank_even (
        .clk         (clk),
        .reset_i     (reset_i),
        .fip_i       (fip_even_o),
        .fill_i      (fill_even_i),
        .fill_fip_i  (fill_fip_i),   // shared fill bus, strobe picks the bank
        .fill_line_i (fill_line_i),
        .line_o      (line_even_o),
        .miss_o      (miss_even_o)
    );

    ////////////////////////////////////////////////////////////
    // odd bank
    ////////////////////////////////////////////////////////////

    fip_bank #(.PARITY(1'b1)) i_fip_bank_odd (
        .clk            (clk),
        .reset_i        (reset_i),
        .cf_sel_i       (cf_sel),
        .init_fip_i     (init_fip_odd),
        .wb_fip_i       (wb_fip_odd_i),
        .bp_fip_i       (bp_fip_odd_i),
        .latch_loaded_i (latch_loaded_odd_i),
        .fip_o          (fip_odd_o)
    );

    icache_bank i_icache_bank_odd (
        .clk         (clk),
        .reset_i     (reset_i),
        .fip_i       (fip_odd_o),
        .fill_i      (fill_odd_i),
        .fill_fip_i  (fill_fip_i),
        .fill_line_i (fill_line_i),
        .line_o      (line_odd_o),
        .miss_o      (miss_odd_o)
    );

endmodule

// ==== verification/tb_fetch_unit.sv ====
`timescale 1ns/1ns

module tb_fetch_unit;

    localparam int W = fetch_pkg::FIP_W;

    logic                          clk = 1'b0;
    logic                          reset_i = 1'b1;
    logic                          init_i, resteer_i, branch_i;
    logic [fetch_pkg::ADDR_W-1:0]  init_addr_i;
    logic [W-1:0]                  wb_fip_even_i, wb_fip_odd_i, bp_fip_even_i, bp_fip_odd_i;
    logic                          latch_loaded_even_i, latch_loaded_odd_i;
    logic                          fill_even_i, fill_odd_i;
    logic [W-1:0]                  fill_fip_i;
    logic [icache_pkg::LINE_W-1:0] fill_line_i;
    logic [W-1:0]                  fip_even_o, fip_odd_o;
    logic [icache_pkg::LINE_W-1:0] line_even_o, line_odd_o;
    logic                          miss_even_o, miss_odd_o;

    // expectations, armed for a single edge
    logic                          chk_fip, chk_miss_e, chk_miss_o, chk_line_e, chk_line_o;
    logic [W-1:0]                  exp_fip_e, exp_fip_o;
    logic [W-1:0]                  reg_e, reg_o;  // model of the two line registers
    logic                          exp_miss;
    logic [icache_pkg::LINE_W-1:0] exp_line;
    logic [31:0]                   lcg_state = 32'h77e079f7;
    int                            errors = 0;
    int                            checks = 0;
    int                            tests = 0;

    fetch_unit i_fetch_unit (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // checkers
    ////////////////////////////////////////////////////////////

    a_fip_even: assert property (@(posedge clk) disable iff (reset_i)
        chk_fip |-> fip_even_o == exp_fip_e) else begin
        errors++;
        $display("ERR fip_even_o expected %h got %h", exp_fip_e, $sampled(fip_even_o));
    end
    a_fip_odd: assert property (@(posedge clk) disable iff (reset_i)
        chk_fip |-> fip_odd_o == exp_fip_o) else begin
        errors++;
        $display("ERR fip_odd_o expected %h got %h", exp_fip_o, $sampled(fip_odd_o));
    end
    a_miss_even: assert property (@(posedge clk) disable iff (reset_i)
        chk_miss_e |-> miss_even_o == exp_miss) else begin
        errors++;
        $display("ERR miss_even_o expected %h got %h", exp_miss, $sampled(miss_even_o));
    end
    a_miss_odd: assert property (@(posedge clk) disable iff (reset_i)
        chk_miss_o |-> miss_odd_o == exp_miss) else begin
        errors++;
        $display("ERR miss_odd_o expected %h got %h", exp_miss, $sampled(miss_odd_o));
    end
    a_line_even: assert property (@(posedge clk) disable iff (reset_i)
        chk_line_e |-> line_even_o == exp_line) else begin
        errors++;
        $display("ERR line_even_o expected %h got %h", exp_line, $sampled(line_even_o));
    end
    a_line_odd: assert property (@(posedge clk) disable iff (reset_i)
        chk_line_o |-> line_odd_o == exp_line) else begin
        errors++;
        $display("ERR line_odd_o expected %h got %h", exp_line, $sampled(line_odd_o));
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rising edge samples what was armed, falling edge drives the next cycle
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
        {chk_fip, chk_miss_e, chk_miss_o, chk_line_e, chk_line_o} = '0;
    endtask

    task automatic expect_fip(input logic [W-1:0] fe, input logic [W-1:0] fo);
        exp_fip_e = fe;
        exp_fip_o = fo;
        chk_fip   = 1'b1;
        checks++;
    endtask

    // both banks share one expected value, arming one leaves the other armed
    task automatic expect_miss(input bit odd, input logic value);
        exp_miss = value;
        if (odd) begin
            chk_miss_o = 1'b1;
        end else begin
            chk_miss_e = 1'b1;
        end
        checks++;
    endtask

    task automatic expect_line(input bit odd, input logic [icache_pkg::LINE_W-1:0] value);
        exp_line   = value;
        chk_line_e = !odd;
        chk_line_o = odd;
        checks++;
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        $display("%-20s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic init_split(input bit odd_start);
        logic [31:0]  rnd;
        logic [W-1:0] line;
        rnd         = lcg_next();
        line        = {rnd[W-1:1], odd_start};
        init_addr_i = {line, rnd[31:28]};  // any byte offset
        init_i      = 1'b1;
        if (odd_start) begin
            expect_fip(line + 1, line);
        end else begin
            expect_fip(line, line + 1);
        end
        next_cycle();
        init_i = 1'b0;
        expect_fip(exp_fip_e + 2, exp_fip_o + 2);
        next_cycle();
        reg_e = exp_fip_e;
        reg_o = exp_fip_o;
    endtask

    task automatic sequential_advance();
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd                 = lcg_next();
            latch_loaded_even_i = (i == 0) | rnd[5];   // first cycle steps even only
            latch_loaded_odd_i  = (i != 0) & rnd[9];
            expect_fip(reg_e, reg_o);
            next_cycle();
            reg_e = latch_loaded_even_i ? reg_e + 2 : reg_e;
            reg_o = latch_loaded_odd_i ? reg_o + 2 : reg_o;
        end
        latch_loaded_even_i = 1'b0;
        latch_loaded_odd_i  = 1'b0;
        expect_fip(reg_e, reg_o);
        next_cycle();
    endtask

    task automatic source_priority();
        logic [31:0]  rnd;
        logic [W-1:0] line;
        rnd           = lcg_next();
        line          = {rnd[W-1:1], 1'b0};
        init_addr_i   = {line, 4'h0};
        rnd           = lcg_next();
        wb_fip_even_i = {rnd[W-1:1], 1'b0};
        wb_fip_odd_i  = {rnd[W:2], 1'b1};
        rnd           = lcg_next();
        bp_fip_even_i = {rnd[W-1:1], 1'b0};
        bp_fip_odd_i  = {rnd[W:2], 1'b1};
        {init_i, resteer_i, branch_i} = 3'b110;
        expect_fip(line, line + 1);
        next_cycle();
        {init_i, resteer_i, branch_i} = 3'b011;
        expect_fip(wb_fip_even_i, wb_fip_odd_i);
        next_cycle();
        {init_i, resteer_i, branch_i} = 3'b001;
        expect_fip(bp_fip_even_i, bp_fip_odd_i);
        next_cycle();
        {init_i, resteer_i, branch_i} = 3'b000;
        expect_fip(bp_fip_even_i + 2, bp_fip_odd_i + 2);  // register took the branch line
        next_cycle();
    endtask

    task automatic miss_fill_hit(input bit odd);
        logic [31:0]                   rnd;
        logic [W-1:0]                  line;
        logic [W-1:0]                  other_tag;
        logic [icache_pkg::LINE_W-1:0] data;
        rnd       = lcg_next();
        line      = {rnd[W-1:1], odd};
        other_tag = line ^ (W'(1) << (icache_pkg::INDEX_W + 1));  // lowest tag bit
        data      = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        // a branch every cycle pins both banks
        branch_i      = 1'b1;
        bp_fip_even_i = odd ? {line[W-1:1], 1'b0} : line;
        bp_fip_odd_i  = odd ? line : {line[W-1:1], 1'b1};
        next_cycle();
        expect_miss(odd, 1'b1);
        next_cycle();
        fill_even_i = !odd;
        fill_odd_i  = odd;
        fill_fip_i  = line;
        fill_line_i = data;
        next_cycle();
        fill_even_i = 1'b0;
        fill_odd_i  = 1'b0;
        expect_miss(odd, 1'b1);  // lookup on the fill edge still saw an empty entry
        next_cycle();
        expect_miss(odd, 1'b0);
        expect_line(odd, data);
        next_cycle();
        // refill the line that hits now
        fill_even_i = !odd;
        fill_odd_i  = odd;
        next_cycle();
        fill_even_i = 1'b0;
        fill_odd_i  = 1'b0;
        expect_miss(odd, 1'b1);  // bank busy filling
        next_cycle();
        if (odd) begin
            bp_fip_odd_i = other_tag;
        end else begin
            bp_fip_even_i = other_tag;
        end
        next_cycle();
        expect_miss(odd, 1'b1);
        next_cycle();
        branch_i = 1'b0;
    endtask

    initial begin
        int errs;
        {init_i, resteer_i, branch_i} = '0;
        init_addr_i         = '0;
        wb_fip_even_i       = '0;
        wb_fip_odd_i        = '0;
        bp_fip_even_i       = '0;
        bp_fip_odd_i        = '0;
        latch_loaded_even_i = 1'b0;
        latch_loaded_odd_i  = 1'b0;
        fill_even_i         = 1'b0;
        fill_odd_i          = 1'b0;
        fill_fip_i          = '0;
        fill_line_i         = '0;
        {chk_fip, chk_miss_e, chk_miss_o, chk_line_e, chk_line_o} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        errs = errors;
        expect_fip(0, 1);
        expect_miss(1'b0, 1'b0);
        expect_miss(1'b1, 1'b0);
        next_cycle();
        report("reset", errs);
        errs = errors;
        init_split(1'b0);
        init_split(1'b1);
        report("init split", errs);
        errs = errors;
        sequential_advance();
        report("sequential advance", errs);
        errs = errors;
        source_priority();
        report("source priority", errs);
        errs = errors;
        miss_fill_hit(1'b0);
        miss_fill_hit(1'b1);
        report("miss fill hit", errs);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
